/* common/display_macros.svh */
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// Horizontal raster in pixel clocks
`define DISP_H_ACTIVE 64
`define DISP_H_FRONT 4
`define DISP_H_SYNC 8
`define DISP_H_BACK 4
`define DISP_H_TOTAL (`DISP_H_ACTIVE + `DISP_H_FRONT + `DISP_H_SYNC + `DISP_H_BACK)

// Vertical raster in lines
`define DISP_V_ACTIVE 32
`define DISP_V_FRONT 2
`define DISP_V_SYNC 2
`define DISP_V_BACK 2
`define DISP_V_TOTAL (`DISP_V_ACTIVE + `DISP_V_FRONT + `DISP_V_SYNC + `DISP_V_BACK)

// Memory fetch geometry
`define DISP_BURST_BYTES 64
`define DISP_BANK_PIXELS 1024
`define DISP_FRAME_PIXELS (`DISP_H_ACTIVE * `DISP_V_ACTIVE)

`endif

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    typedef logic [15:0] rgb565_t;      // 5 red, 6 green, 5 blue
    typedef logic [10:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // All three strobes are active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_sync_t;

endpackage : video_pkg

`default_nettype wire

/* common/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    typedef logic [23:0] dma_addr_t;    // 16 MB byte space
    typedef logic [63:0] dma_data_t;    // One beat
    typedef logic [11:0] dma_bytes_t;

    // Read request, valid/ready travel beside it
    typedef struct packed {
        dma_addr_t addr;
        dma_bytes_t bytes;
    } dma_req_t;

    // One response beat
    typedef struct packed {
        logic last;                     // Final beat of the burst
        dma_addr_t addr;                // Byte address of this beat
        dma_data_t data;
    } dma_resp_t;

endpackage : dma_pkg

`default_nettype wire

/* rtl/pixel_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_ram (
    input wire logic i_clk,
    input wire logic [7:0] i_addr,
    input wire logic i_wena,
    input wire dma_pkg::dma_data_t i_wdata,
    output dma_pkg::dma_data_t o_rdata
);

    import dma_pkg::*;

    dma_data_t mem [0:255];             // Four pixels per word

    always_ff @(posedge i_clk) begin
        if (i_wena) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];         // Registered read, old data on a write
    end

endmodule : pixel_ram

`default_nettype wire

/* rtl/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module video_timing (
    input wire logic i_clk,
    input wire logic i_nrst,
    output video_pkg::video_sync_t o_sync
);

    import video_pkg::*;

    localparam int H_TOTAL = `DISP_H_TOTAL;
    localparam int V_TOTAL = `DISP_V_TOTAL;
    localparam int H_SYNC_START = `DISP_H_ACTIVE + `DISP_H_FRONT;
    localparam int H_SYNC_END = H_SYNC_START + `DISP_H_SYNC;
    localparam int V_SYNC_START = `DISP_V_ACTIVE + `DISP_V_FRONT;
    localparam int V_SYNC_END = V_SYNC_START + `DISP_V_SYNC;

    hcount_t hcnt;
    vcount_t vcnt;
    logic h_end;
    logic v_end;
    video_sync_t sync_next;

    assign h_end = (hcnt == hcount_t'(H_TOTAL - 1));
    assign v_end = (vcnt == vcount_t'(V_TOTAL - 1));

    // Pixel and line counters
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (h_end) begin
            hcnt <= '0;
            if (v_end) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // Decode from the current counts
    always_comb begin
        sync_next.hsync = (hcnt >= hcount_t'(H_SYNC_START)) && (hcnt < hcount_t'(H_SYNC_END));
        sync_next.vsync = (vcnt >= vcount_t'(V_SYNC_START)) && (vcnt < vcount_t'(V_SYNC_END));
        sync_next.de = (hcnt < hcount_t'(`DISP_H_ACTIVE))
                    && (vcnt < vcount_t'(`DISP_V_ACTIVE));
    end

    // Outputs lag the counters by one clock
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_sync <= '0;
        end else begin
            o_sync <= sync_next;
        end
    end

    // Active video never overlaps a sync pulse
    a_de_outside_sync : assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_sync.de |-> !(o_sync.hsync || o_sync.vsync)
    );

endmodule : video_timing

`default_nettype wire

/* framebuf/framebuf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module framebuf (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire video_pkg::video_sync_t i_sync,
    output video_pkg::video_sync_t o_sync,             // i_sync two clocks later
    output video_pkg::rgb565_t o_rgb,
    input wire logic i_req_ready,
    output logic o_req_valid,
    output dma_pkg::dma_req_t o_req,
    input wire logic i_resp_valid,
    input wire dma_pkg::dma_resp_t i_resp,
    output logic o_resp_ready
);

    import video_pkg::*;
    import dma_pkg::*;

    localparam int BURST_SHIFT = $clog2(`DISP_BURST_BYTES);
    localparam int UNIT_BITS = $bits(dma_addr_t) - BURST_SHIFT;
    localparam int BANK_UNITS = (`DISP_BANK_PIXELS * 2) / `DISP_BURST_BYTES;
    localparam int FRAME_UNITS = (`DISP_FRAME_PIXELS * 2) / `DISP_BURST_BYTES;

    typedef enum logic [1:0] {
        ST_REQUEST,
        ST_WRITING,
        ST_IDLE
    } state_t;

    typedef struct packed {
        video_sync_t sync_d1;
        video_sync_t sync_d2;
        logic [10:0] raddr;                 // Displayed pixel count in the frame
        logic [1:0] raddr_z;                // Lane of the pixel being read
        logic pingpong;                     // 1 shows ping, 0 shows pong
        logic bank_z;                       // Bank the RAM output came from
        logic [UNIT_BITS-1:0] unit;         // 64-byte unit index
        state_t state;
        logic req_valid;
        logic resp_ready;
        rgb565_t rgb;
    } framebuf_regs_t;

    // Unit starts at the last one so the first swap fetches unit 0
    localparam framebuf_regs_t REGS_RESET = '{
        sync_d1: '0,
        sync_d2: '0,
        raddr: '0,
        raddr_z: '0,
        pingpong: 1'b0,
        bank_z: 1'b0,
        unit: UNIT_BITS'(FRAME_UNITS - 1),
        state: ST_IDLE,
        req_valid: 1'b0,
        resp_ready: 1'b0,
        rgb: '0
    };

    framebuf_regs_t r;
    framebuf_regs_t rin;

    logic [7:0] ping_addr;
    logic [7:0] pong_addr;
    logic ping_wena;
    logic pong_wena;
    dma_data_t ping_rdata;
    dma_data_t pong_rdata;
    dma_data_t show_rdata;

    // Shown bank follows the read pointer, hidden bank takes response beats
    assign ping_addr = r.pingpong ? r.raddr[9:2] : i_resp.addr[10:3];
    assign pong_addr = r.pingpong ? i_resp.addr[10:3] : r.raddr[9:2];
    assign ping_wena = i_resp_valid & ~r.pingpong;
    assign pong_wena = i_resp_valid & r.pingpong;
    assign show_rdata = r.bank_z ? ping_rdata : pong_rdata;

    pixel_ram ping (
        .i_clk(i_clk),
        .i_addr(ping_addr),
        .i_wena(ping_wena),
        .i_wdata(i_resp.data),
        .o_rdata(ping_rdata)
    );

    pixel_ram pong (
        .i_clk(i_clk),
        .i_addr(pong_addr),
        .i_wena(pong_wena),
        .i_wdata(i_resp.data),
        .o_rdata(pong_rdata)
    );

    always_comb begin
        framebuf_regs_t v;
        logic [10:0] raddr_next;

        v = r;
        raddr_next = r.raddr + 11'd1;

        v.sync_d1 = i_sync;
        v.sync_d2 = r.sync_d1;
        v.bank_z = r.pingpong;
        if (i_sync.de) begin
            v.raddr = raddr_next;
            v.raddr_z = r.raddr[1:0];
        end

        case (r.state)
            ST_REQUEST: begin
                if (r.req_valid && i_req_ready) begin
                    v.req_valid = 1'b0;
                    v.resp_ready = 1'b1;
                    v.state = ST_WRITING;
                end
            end
            ST_WRITING: begin
                if (i_resp_valid && i_resp.last) begin
                    v.resp_ready = 1'b0;
                    if (&i_resp.addr[10:3]) begin   // Last word of the bank
                        v.state = ST_IDLE;
                    end else begin
                        v.req_valid = 1'b1;
                        v.unit = r.unit + 1'b1;
                        v.state = ST_REQUEST;
                    end
                end
            end
            ST_IDLE: begin
                // Halfway through the frame the freshly filled bank goes on screen
                if (i_sync.de && !r.raddr[10] && raddr_next[10]) begin
                    v.pingpong = ~r.pingpong;
                    if (r.unit >= UNIT_BITS'(FRAME_UNITS - 1)) begin
                        v.unit = '0;            // Start of the next frame
                    end else begin
                        v.unit = r.unit + 1'b1;
                    end
                    v.req_valid = 1'b1;
                    v.state = ST_REQUEST;
                end
            end
            default: begin
                v.state = ST_IDLE;
            end
        endcase

        // Frame start, fetch the second half into the bank just hidden
        if (i_sync.vsync && !r.sync_d1.vsync) begin
            v.pingpong = ~r.pingpong;
            v.raddr = '0;
            v.unit = UNIT_BITS'(BANK_UNITS);
            v.req_valid = 1'b1;
            v.state = ST_REQUEST;
        end

        if (r.sync_d1.de) begin
            v.rgb = show_rdata[16 * r.raddr_z +: 16];
        end else begin
            v.rgb = '0;
        end

        rin = v;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= REGS_RESET;
        end else begin
            r <= rin;
        end
    end

    always_comb begin
        o_sync = r.sync_d2;
        o_rgb = r.rgb;
        o_req_valid = r.req_valid;
        o_req.addr = {r.unit, {BURST_SHIFT{1'b0}}};  // Always burst aligned
        o_req.bytes = dma_bytes_t'(`DISP_BURST_BYTES);
        o_resp_ready = r.resp_ready;
    end

    // A stalled request keeps its address
    a_req_stable : assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_req_valid && !i_req_ready) |=> (o_req_valid && $stable(o_req.addr))
    );

    // Memory only sends beats that were asked for
    a_write_when_ready : assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (ping_wena || pong_wena) |-> o_resp_ready
    );

endmodule : framebuf

`default_nettype wire

/* rtl/display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top (
    input wire logic i_clk,
    input wire logic i_nrst,
    output logic o_hsync,
    output logic o_vsync,
    output logic o_de,
    output video_pkg::rgb565_t o_rgb,
    input wire logic i_req_ready,
    output logic o_req_valid,
    output dma_pkg::dma_req_t o_req,
    input wire logic i_resp_valid,
    input wire dma_pkg::dma_resp_t i_resp,
    output logic o_resp_ready
);

    import video_pkg::*;

    video_sync_t raster_sync;           // Straight from the counters
    video_sync_t video_sync;            // Aligned with o_rgb

    video_timing video_timing_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .o_sync(raster_sync)
    );

    framebuf framebuf_i (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_sync(raster_sync),
        .o_sync(video_sync),
        .o_rgb(o_rgb),
        .i_req_ready(i_req_ready),
        .o_req_valid(o_req_valid),
        .o_req(o_req),
        .i_resp_valid(i_resp_valid),
        .i_resp(i_resp),
        .o_resp_ready(o_resp_ready)
    );

    assign o_hsync = video_sync.hsync;
    assign o_vsync = video_sync.vsync;
    assign o_de = video_sync.de;

endmodule : display_top

`default_nettype wire

/* tb/dma_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module dma_mem_model (
    input wire logic i_clk,
    input wire logic i_req_valid,
    input wire dma_pkg::dma_req_t i_req,
    output logic o_req_ready,
    output logic o_resp_valid,
    output dma_pkg::dma_resp_t o_resp,
    input wire logic i_resp_ready,
    output logic o_fault            // Raised on the first problem seen here
);

    import video_pkg::*;
    import dma_pkg::*;

    localparam int BURST = `DISP_BURST_BYTES;
    localparam int BEATS = BURST / 8;
    localparam int FRAME_UNITS = (`DISP_FRAME_PIXELS * 2) / BURST;
    localparam int REQ_LIMIT = 8000;    // Longer than any idle gap in a frame
    localparam int READY_LIMIT = 16;

    logic [15:0] lfsr_q;
    int prev_unit;

    // Unique over the 2048 pixels of a frame since the multiplier is odd
    function automatic rgb565_t pixel_value(input int k);
        logic [15:0] idx;
        idx = k[15:0];
        return rgb565_t'((idx * 16'h9E37) ^ 16'h5A5A);
    endfunction

    // Four pixels per beat, lowest lane first
    function automatic dma_data_t beat_data(input dma_addr_t addr);
        dma_data_t d;
        for (int j = 0; j < 4; j++) begin
            d[16 * j +: 16] = pixel_value(int'(addr) / 2 + j);
        end
        return d;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        o_fault = 1'b1;
    endtask

    task automatic plain_failure(input string msg);
        $display("Memory model stopped: %s", msg);
        o_fault = 1'b1;
    endtask

    task automatic check_request(input dma_req_t got, input dma_req_t exp);
        if (got !== exp) begin
            value_error($sformatf("request addr %h bytes %0d, expected addr %h bytes %0d",
                                  got.addr, got.bytes, exp.addr, exp.bytes));
        end
    endtask

    task automatic serve_burst;
        int stall;
        int lat;
        int gap;
        int waited;
        int exp_unit;
        dma_req_t held;
        dma_req_t exp;
        dma_addr_t addr;

        waited = 0;
        while (!i_req_valid) begin
            @(negedge i_clk);
            waited++;
            if (waited > REQ_LIMIT) begin
                plain_failure("no request arrived in time");
                return;
            end
        end
        held = i_req;
        take_bits(2, stall);
        repeat (stall) begin
            @(negedge i_clk);
            if (!i_req_valid || i_req !== held) begin
                value_error("request changed while stalled");
            end
        end
        o_req_ready = 1'b1;
        @(negedge i_clk);
        o_req_ready = 1'b0;

        // Units run in order and wrap to 0 after the last one of the frame
        exp_unit = (prev_unit + 1) % FRAME_UNITS;
        exp.addr = dma_addr_t'(exp_unit * BURST);
        exp.bytes = dma_bytes_t'(BURST);
        check_request(held, exp);
        prev_unit = exp_unit;

        take_bits(3, lat);
        repeat (lat) @(negedge i_clk);
        for (int b = 0; b < BEATS; b++) begin
            take_bits(1, gap);
            repeat (gap) @(negedge i_clk);
            waited = 0;
            while (!i_resp_ready) begin
                @(negedge i_clk);
                waited++;
                if (waited > READY_LIMIT) begin
                    plain_failure("a response beat waited too long for ready");
                    return;
                end
            end
            addr = held.addr + dma_addr_t'(8 * b);
            o_resp.last = (b == BEATS - 1);
            o_resp.addr = addr;
            o_resp.data = beat_data(addr);
            o_resp_valid = 1'b1;
            @(negedge i_clk);
            o_resp_valid = 1'b0;
        end
    endtask

    initial begin
        o_req_ready = 1'b0;
        o_resp_valid = 1'b0;
        o_resp = '0;
        o_fault = 1'b0;
        lfsr_q = 16'd26520;
        prev_unit = FRAME_UNITS - 1;        // First swap after reset asks for unit 0
        while (!o_fault) begin
            serve_burst();
        end
    end

endmodule : dma_mem_model

`default_nettype wire

/* tb/display_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module display_top_tb;

    import video_pkg::*;
    import dma_pkg::*;

    localparam int H_TOTAL = `DISP_H_TOTAL;
    localparam int V_TOTAL = `DISP_V_TOTAL;
    localparam int FRAME_LIMIT = 2 * H_TOTAL * V_TOTAL;
    localparam int CHECKED_FRAMES = 4;

    logic clk;
    logic nrst;
    logic hsync;
    logic vsync;
    logic de;
    rgb565_t rgb;
    logic req_ready;
    logic req_valid;
    dma_req_t req;
    logic resp_valid;
    dma_resp_t resp;
    logic resp_ready;
    logic mem_fault;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    display_top display_top_i (
        .i_clk(clk),
        .i_nrst(nrst),
        .o_hsync(hsync),
        .o_vsync(vsync),
        .o_de(de),
        .o_rgb(rgb),
        .i_req_ready(req_ready),
        .o_req_valid(req_valid),
        .o_req(req),
        .i_resp_valid(resp_valid),
        .i_resp(resp),
        .o_resp_ready(resp_ready)
    );

    dma_mem_model mem_i (
        .i_clk(clk),
        .i_req_valid(req_valid),
        .i_req(req),
        .o_req_ready(req_ready),
        .o_resp_valid(resp_valid),
        .o_resp(resp),
        .i_resp_ready(resp_ready),
        .o_fault(mem_fault)
    );

    task automatic stop_with_failure;
        $display("Regression failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timed_out(input string what);
        $display("Timed out waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_pixel(input rgb565_t got, input rgb565_t exp, input string what);
        if (got !== exp) value_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_count(input hcount_t got, input hcount_t exp, input string what);
        if (got !== exp) value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) value_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Returns at the first sample with vsync high after a low one
    task automatic wait_vsync_rise;
        logic prev;
        int waited;
        waited = 0;
        prev = vsync;
        @(negedge clk);
        while (!(vsync && !prev)) begin
            prev = vsync;
            waited++;
            if (waited > FRAME_LIMIT) timed_out("vsync");
            @(negedge clk);
        end
    endtask

    // Runs from one vsync rise to the next
    task automatic measure_frame;
        int k;
        int de_run;
        int hs_run;
        int vs_run;
        int lines;
        int hs_pulses;
        int waited;
        bit done;
        logic prev_de;
        logic prev_hs;
        logic prev_vs;

        k = 0;
        de_run = 0;
        hs_run = 0;
        vs_run = 1;                     // The rising sample itself
        lines = 0;
        hs_pulses = 0;
        waited = 0;
        done = 1'b0;
        prev_de = de;
        prev_hs = hsync;
        prev_vs = 1'b1;
        while (!done) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME_LIMIT) timed_out("the next vsync");
            if (vsync && !prev_vs) begin
                done = 1'b1;
            end else begin
                if (de) begin
                    check_pixel(rgb, mem_i.pixel_value(k), $sformatf("pixel %0d", k));
                    k++;
                    de_run++;
                end else begin
                    check_pixel(rgb, '0, "blanked pixel");
                    if (prev_de) begin
                        check_count(hcount_t'(de_run), hcount_t'(`DISP_H_ACTIVE), "de per line");
                        de_run = 0;
                        lines++;
                    end
                end
                if (hsync) begin
                    hs_run++;
                end else if (prev_hs) begin
                    check_count(hcount_t'(hs_run), hcount_t'(`DISP_H_SYNC), "hsync width");
                    hs_run = 0;
                    hs_pulses++;
                end
                if (vsync) begin
                    vs_run++;
                end else if (prev_vs) begin
                    check_count(hcount_t'(vs_run), hcount_t'(`DISP_V_SYNC * H_TOTAL),
                                "vsync width");
                end
                prev_de = de;
                prev_hs = hsync;
                prev_vs = vsync;
            end
        end
        check_count(hcount_t'(lines), hcount_t'(`DISP_V_ACTIVE), "active lines");
        check_count(hcount_t'(hs_pulses), hcount_t'(V_TOTAL), "hsync pulses per frame");
    endtask

    always @(posedge mem_fault) begin
        stop_with_failure();
    end

    initial begin
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag(req_valid, 1'b0, "o_req_valid in reset");
        check_flag(resp_ready, 1'b0, "o_resp_ready in reset");
        check_flag(de, 1'b0, "o_de in reset");
        check_pixel(rgb, '0, "o_rgb in reset");
        nrst = 1'b1;

        wait_vsync_rise();              // Pixels before the first vsync are undefined
        repeat (CHECKED_FRAMES) measure_frame();

        $display("Regression passed");
        $finish;
    end

endmodule : display_top_tb

`default_nettype wire

/* display_top.f */
+incdir+common
common/video_pkg.sv
common/dma_pkg.sv
rtl/pixel_ram.sv
rtl/video_timing.sv
framebuf/framebuf.sv
rtl/display_top.sv
tb/dma_mem_model.sv
tb/display_top_tb.sv
